// ==== flist.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
id_regfile.sv
id_decoder.sv
id_branch.sv
id_stage.sv
tb_id_stage.sv

// ==== id_branch.sv ====
`timescale 1ns/100ps
`include "id_settings.svh"

module id_branch (
    input  pipe_pkg::br_kind_t kind,
    input  isa_pkg::word_t     pc,
    input  isa_pkg::word_t     inst,
    input  isa_pkg::word_t     rs_val,
    input  isa_pkg::word_t     rt_val,
    output pipe_pkg::br_t      br
);

    isa_pkg::imm_t  offset;
    isa_pkg::jidx_t jidx;
    isa_pkg::word_t pc_next;
    isa_pkg::word_t rel_target;
    isa_pkg::word_t abs_target;
    logic           rs_eq_rt;
    logic           rs_neg;
    logic           rs_zero;
    logic           cond_br;
    logic           jump;

    assign offset  = inst[15:0];
    assign jidx    = inst[25:0];
    assign pc_next = pc + isa_pkg::word_t'(`PC_STEP);

    assign rel_target = pc_next + {{(`DATA_WD-18){offset[15]}}, offset, 2'b00};
    assign abs_target = {pc_next[`DATA_WD-1 -: 4], jidx, 2'b00};  // Stays in 256 MB region

    assign rs_eq_rt = (rs_val == rt_val);
    assign rs_neg   = rs_val[`DATA_WD-1];
    assign rs_zero  = (rs_val == '0);

    assign cond_br = kind.beq | kind.bne | kind.bgez | kind.bltz | kind.bgtz | kind.blez;
    assign jump    = kind.j | kind.jal | kind.jr | kind.jalr;

    assign br.br_e = jump
                   | (kind.beq  &  rs_eq_rt)
                   | (kind.bne  & ~rs_eq_rt)
                   | (kind.bgez & ~rs_neg)
                   | (kind.bltz &  rs_neg)
                   | (kind.bgtz & ~rs_neg & ~rs_zero)
                   | (kind.blez & (rs_neg | rs_zero));

    assign br.br_addr = cond_br            ? rel_target :
                        (kind.j | kind.jal) ? abs_target :
                        (kind.jr | kind.jalr) ? rs_val :
                        '0;

endmodule

// ==== id_decoder.sv ====
`timescale 1ns/100ps
`include "id_settings.svh"

module id_decoder (
    input  isa_pkg::word_t      inst,
    output pipe_pkg::dec_ctrl_t ctrl
);

    isa_pkg::inst_fields_t f;
    logic special;
    logic sa_zero;
    logic rs_zero;
    logic inst_addu, inst_subu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_slt, inst_sltu, inst_sllv, inst_srlv, inst_srav;
    logic inst_sll, inst_srl, inst_sra, inst_jr, inst_jalr;
    logic inst_addiu, inst_andi, inst_ori, inst_xori, inst_slti, inst_sltiu, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bltz, inst_bgtz, inst_blez, inst_j, inst_jal;
    logic rr_op;    // rs op rt into rd
    logic sh_imm;   // Shift by sa field
    logic simm_op;  // Sign-extended immediate operand
    logic zimm_op;  // Zero-extended immediate operand

    assign f       = inst;
    assign special = (f.op == isa_pkg::OP_SPECIAL);
    assign sa_zero = (f.sa == '0);
    assign rs_zero = (f.rs == '0);

    assign inst_addu = special && sa_zero && f.funct == isa_pkg::F_ADDU;
    assign inst_subu = special && sa_zero && f.funct == isa_pkg::F_SUBU;
    assign inst_and  = special && sa_zero && f.funct == isa_pkg::F_AND;
    assign inst_or   = special && sa_zero && f.funct == isa_pkg::F_OR;
    assign inst_xor  = special && sa_zero && f.funct == isa_pkg::F_XOR;
    assign inst_nor  = special && sa_zero && f.funct == isa_pkg::F_NOR;
    assign inst_slt  = special && sa_zero && f.funct == isa_pkg::F_SLT;
    assign inst_sltu = special && sa_zero && f.funct == isa_pkg::F_SLTU;
    assign inst_sllv = special && sa_zero && f.funct == isa_pkg::F_SLLV;
    assign inst_srlv = special && sa_zero && f.funct == isa_pkg::F_SRLV;
    assign inst_srav = special && sa_zero && f.funct == isa_pkg::F_SRAV;
    assign inst_sll  = special && rs_zero && f.funct == isa_pkg::F_SLL;
    assign inst_srl  = special && rs_zero && f.funct == isa_pkg::F_SRL;
    assign inst_sra  = special && rs_zero && f.funct == isa_pkg::F_SRA;
    assign inst_jr   = special && f.rt == '0 && f.rd == '0 && sa_zero
                       && f.funct == isa_pkg::F_JR;
    assign inst_jalr = special && f.rt == '0 && sa_zero && f.funct == isa_pkg::F_JALR;

    assign inst_addiu = (f.op == isa_pkg::OP_ADDIU);
    assign inst_andi  = (f.op == isa_pkg::OP_ANDI);
    assign inst_ori   = (f.op == isa_pkg::OP_ORI);
    assign inst_xori  = (f.op == isa_pkg::OP_XORI);
    assign inst_slti  = (f.op == isa_pkg::OP_SLTI);
    assign inst_sltiu = (f.op == isa_pkg::OP_SLTIU);
    assign inst_lui   = (f.op == isa_pkg::OP_LUI);
    assign inst_lw    = (f.op == isa_pkg::OP_LW);
    assign inst_sw    = (f.op == isa_pkg::OP_SW);

    assign inst_beq  = (f.op == isa_pkg::OP_BEQ);
    assign inst_bne  = (f.op == isa_pkg::OP_BNE);
    assign inst_bgez = (f.op == isa_pkg::OP_REGIMM) && f.rt == isa_pkg::RT_BGEZ;
    assign inst_bltz = (f.op == isa_pkg::OP_REGIMM) && f.rt == isa_pkg::RT_BLTZ;
    assign inst_bgtz = (f.op == isa_pkg::OP_BGTZ) && f.rt == '0;
    assign inst_blez = (f.op == isa_pkg::OP_BLEZ) && f.rt == '0;
    assign inst_j    = (f.op == isa_pkg::OP_J);
    assign inst_jal  = (f.op == isa_pkg::OP_JAL);

    assign rr_op   = inst_addu | inst_subu | inst_and | inst_or | inst_xor | inst_nor
                   | inst_slt | inst_sltu | inst_sllv | inst_srlv | inst_srav;
    assign sh_imm  = inst_sll | inst_srl | inst_sra;
    assign simm_op = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign zimm_op = inst_andi | inst_ori | inst_xori;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[`ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw
                               | inst_jal | inst_jalr;  // Link value is pc + 8
        ctrl.alu_op[`ALU_SUB]  = inst_subu;
        ctrl.alu_op[`ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[`ALU_SLTU] = inst_sltu | inst_sltiu;
        ctrl.alu_op[`ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[`ALU_NOR]  = inst_nor;
        ctrl.alu_op[`ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[`ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[`ALU_SLL]  = inst_sll | inst_sllv;
        ctrl.alu_op[`ALU_SRL]  = inst_srl | inst_srlv;
        ctrl.alu_op[`ALU_SRA]  = inst_sra | inst_srav;
        ctrl.alu_op[`ALU_LUI]  = inst_lui;

        ctrl.sel_src1[0] = rr_op | zimm_op | (simm_op & ~inst_lui);  // rs
        ctrl.sel_src1[1] = inst_jal | inst_jalr;                     // pc
        ctrl.sel_src1[2] = sh_imm;                                   // sa
        ctrl.sel_src2[0] = rr_op | sh_imm;                           // rt
        ctrl.sel_src2[1] = simm_op;
        ctrl.sel_src2[2] = inst_jal | inst_jalr;                     // Constant 8
        ctrl.sel_src2[3] = zimm_op;

        ctrl.mem_en  = inst_lw | inst_sw;
        ctrl.mem_wen = {4{inst_sw}};  // Full word only
        ctrl.rf_we   = rr_op | sh_imm | zimm_op | (simm_op & ~inst_sw) | inst_jal | inst_jalr;

        if (rr_op | sh_imm | inst_jalr) begin
            ctrl.rf_waddr = f.rd;
        end else if (zimm_op | (simm_op & ~inst_sw)) begin
            ctrl.rf_waddr = f.rt;
        end else if (inst_jal) begin
            ctrl.rf_waddr = isa_pkg::reg_addr_t'(`LINK_REG);
        end

        ctrl.br_kind.beq  = inst_beq;
        ctrl.br_kind.bne  = inst_bne;
        ctrl.br_kind.bgez = inst_bgez;
        ctrl.br_kind.bltz = inst_bltz;
        ctrl.br_kind.bgtz = inst_bgtz;
        ctrl.br_kind.blez = inst_blez;
        ctrl.br_kind.j    = inst_j;
        ctrl.br_kind.jal  = inst_jal;
        ctrl.br_kind.jr   = inst_jr;
        ctrl.br_kind.jalr = inst_jalr;
    end

endmodule

// ==== id_regfile.sv ====
`timescale 1ns/100ps
`include "id_settings.svh"

module id_regfile (
    input  logic                clk,
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2,
    input  pipe_pkg::wb_to_rf_t wb_to_rf,
    input  pipe_pkg::fwd_t      ex_fwd,
    input  pipe_pkg::fwd_t      mem_fwd,
    input  pipe_pkg::fwd_t      wb_fwd
);

    isa_pkg::word_t regs [0:`REG_NUM-1];

    // Youngest producer wins
    function automatic isa_pkg::word_t read_port(
        input isa_pkg::reg_addr_t addr,
        input isa_pkg::word_t     stored,
        input pipe_pkg::fwd_t     ex_src,
        input pipe_pkg::fwd_t     mem_src,
        input pipe_pkg::fwd_t     wb_src
    );
        isa_pkg::word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_src.we && ex_src.waddr == addr) begin
            val = ex_src.wdata;
        end else if (mem_src.we && mem_src.waddr == addr) begin
            val = mem_src.wdata;
        end else if (wb_src.we && wb_src.waddr == addr) begin
            val = wb_src.wdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_to_rf.we && wb_to_rf.waddr != '0) begin  // $0 stays zero
            regs[wb_to_rf.waddr] <= wb_to_rf.wdata;
        end
    end

    assign rdata1 = read_port(raddr1, regs[raddr1], ex_fwd, mem_fwd, wb_fwd);
    assign rdata2 = read_port(raddr2, regs[raddr2], ex_fwd, mem_fwd, wb_fwd);

endmodule

// ==== id_settings.svh ====
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

`define DATA_WD    32
`define REG_AW     5
`define REG_NUM    32

// One-hot ALU op, add sits in the top bit
`define ALU_OP_WD  12
`define ALU_ADD    11
`define ALU_SUB    10
`define ALU_SLT    9
`define ALU_SLTU   8
`define ALU_AND    7
`define ALU_NOR    6
`define ALU_OR     5
`define ALU_XOR    4
`define ALU_SLL    3
`define ALU_SRL    2
`define ALU_SRA    1
`define ALU_LUI    0

`define SRC1_WD    3
`define SRC2_WD    4

`define LINK_REG   31
`define PC_STEP    4

`endif

// ==== id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  pipe_pkg::stall_t    stall,
    input  pipe_pkg::if_to_id_t if_to_id,
    input  isa_pkg::word_t      inst_rdata,
    input  pipe_pkg::wb_to_rf_t wb_to_rf,
    input  pipe_pkg::fwd_t      ex_fwd,
    input  pipe_pkg::fwd_t      mem_fwd,
    input  pipe_pkg::fwd_t      wb_fwd,
    input  logic                ex_is_load,
    output pipe_pkg::id_to_ex_t id_to_ex,
    output pipe_pkg::br_t       br,
    output logic                stallreq
);

    pipe_pkg::if_to_id_t   if_to_id_r;
    isa_pkg::inst_fields_t fields;
    pipe_pkg::dec_ctrl_t   ctrl;
    isa_pkg::word_t        rdata1;
    isa_pkg::word_t        rdata2;
    pipe_pkg::br_t         br_raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_to_id_r <= '0;
        end else if (stall.if_stall && !stall.id_stall) begin
            if_to_id_r <= '0;  // Bubble into ID
        end else if (!stall.if_stall) begin
            if_to_id_r <= if_to_id;
        end
    end

    assign fields = inst_rdata;  // SRAM answers for the registered pc

    // Loaded value not ready until MEM
    assign stallreq = ex_is_load && ex_fwd.waddr != '0
                      && (ex_fwd.waddr == fields.rs || ex_fwd.waddr == fields.rt);

    id_regfile u_regfile (
        .clk      (clk),
        .raddr1   (fields.rs),
        .raddr2   (fields.rt),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .wb_to_rf (wb_to_rf),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb_fwd)
    );

    id_decoder u_decoder (
        .inst (inst_rdata),
        .ctrl (ctrl)
    );

    id_branch u_branch (
        .kind   (ctrl.br_kind),
        .pc     (if_to_id_r.pc),
        .inst   (inst_rdata),
        .rs_val (rdata1),
        .rt_val (rdata2),
        .br     (br_raw)
    );

    always_comb begin
        id_to_ex.valid    = if_to_id_r.ce;
        id_to_ex.pc       = if_to_id_r.pc;
        id_to_ex.inst     = inst_rdata;
        id_to_ex.alu_op   = ctrl.alu_op;
        id_to_ex.sel_src1 = ctrl.sel_src1;
        id_to_ex.sel_src2 = ctrl.sel_src2;
        id_to_ex.mem_en   = ctrl.mem_en;
        id_to_ex.mem_wen  = ctrl.mem_wen;
        id_to_ex.rf_we    = ctrl.rf_we;
        id_to_ex.rf_waddr = ctrl.rf_waddr;
        id_to_ex.rdata1   = rdata1;
        id_to_ex.rdata2   = rdata2;
    end

    assign br.br_e    = br_raw.br_e & if_to_id_r.ce;  // A bubble never redirects fetch
    assign br.br_addr = br_raw.br_addr;

endmodule

// ==== isa_pkg.sv ====
`include "id_settings.svh"

package isa_pkg;

    typedef logic [`DATA_WD-1:0]   word_t;
    typedef logic [`REG_AW-1:0]    reg_addr_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;
    typedef logic [4:0]            shamt_t;
    typedef logic [15:0]           imm_t;
    typedef logic [25:0]           jidx_t;
    typedef logic [`ALU_OP_WD-1:0] alu_op_t;

    // R-type view of an instruction word
    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    sa;
        funct_t    funct;
    } inst_fields_t;

    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;  // bltz and bgez, told apart by rt
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_SW      = 6'b101011;

    localparam funct_t F_SLL  = 6'b000000;
    localparam funct_t F_SRL  = 6'b000010;
    localparam funct_t F_SRA  = 6'b000011;
    localparam funct_t F_SLLV = 6'b000100;
    localparam funct_t F_SRLV = 6'b000110;
    localparam funct_t F_SRAV = 6'b000111;
    localparam funct_t F_JR   = 6'b001000;
    localparam funct_t F_JALR = 6'b001001;
    localparam funct_t F_ADDU = 6'b100001;
    localparam funct_t F_SUBU = 6'b100011;
    localparam funct_t F_AND  = 6'b100100;
    localparam funct_t F_OR   = 6'b100101;
    localparam funct_t F_XOR  = 6'b100110;
    localparam funct_t F_NOR  = 6'b100111;
    localparam funct_t F_SLT  = 6'b101010;
    localparam funct_t F_SLTU = 6'b101011;

    localparam reg_addr_t RT_BLTZ = 5'b00000;
    localparam reg_addr_t RT_BGEZ = 5'b00001;

endpackage

// ==== pipe_pkg.sv ====
`include "id_settings.svh"

package pipe_pkg;

    typedef struct packed {
        logic           ce;  // Fetch valid
        isa_pkg::word_t pc;
    } if_to_id_t;

    typedef struct packed {
        logic if_stall;
        logic id_stall;
    } stall_t;

    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } wb_to_rf_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic bgez;
        logic bltz;
        logic bgtz;
        logic blez;
        logic j;
        logic jal;
        logic jr;
        logic jalr;
    } br_kind_t;

    typedef struct packed {
        isa_pkg::alu_op_t    alu_op;
        logic [`SRC1_WD-1:0] sel_src1;  // rs, pc, sa
        logic [`SRC2_WD-1:0] sel_src2;  // rt, simm, 8, zimm
        logic                mem_en;
        logic [3:0]          mem_wen;
        logic                rf_we;
        isa_pkg::reg_addr_t  rf_waddr;
        br_kind_t            br_kind;
    } dec_ctrl_t;

    typedef struct packed {
        logic                valid;
        isa_pkg::word_t      pc;
        isa_pkg::word_t      inst;
        isa_pkg::alu_op_t    alu_op;
        logic [`SRC1_WD-1:0] sel_src1;
        logic [`SRC2_WD-1:0] sel_src2;
        logic                mem_en;
        logic [3:0]          mem_wen;
        logic                rf_we;
        isa_pkg::reg_addr_t  rf_waddr;
        isa_pkg::word_t      rdata1;
        isa_pkg::word_t      rdata2;
    } id_to_ex_t;

    typedef struct packed {
        logic           br_e;
        isa_pkg::word_t br_addr;
    } br_t;

endpackage

// ==== tb_id_stage.sv ====
`timescale 1ns/100ps
`include "id_settings.svh"

module tb_id_stage;

    typedef struct {
        pipe_pkg::stall_t    stall;
        isa_pkg::word_t      pc;
        isa_pkg::word_t      inst;
        pipe_pkg::fwd_t      ex;
        pipe_pkg::fwd_t      mem;
        pipe_pkg::fwd_t      wbf;
        logic                ld;
        pipe_pkg::wb_to_rf_t wr;
        bit                  chk_ctl;
        bit                  chk_dat;
        bit                  chk_br;
        logic                exp_valid;
        isa_pkg::word_t      exp_pc;
        logic                exp_stallreq;
        pipe_pkg::dec_ctrl_t exp_ctl;
        isa_pkg::word_t      exp_rd1;
        isa_pkg::word_t      exp_rd2;
        pipe_pkg::br_t       exp_br;
    } row_t;

    logic                clk;
    logic                rst;
    pipe_pkg::stall_t    stall;
    pipe_pkg::if_to_id_t if_to_id;
    isa_pkg::word_t      inst_rdata;
    pipe_pkg::wb_to_rf_t wb_to_rf;
    pipe_pkg::fwd_t      ex_fwd;
    pipe_pkg::fwd_t      mem_fwd;
    pipe_pkg::fwd_t      wb_fwd;
    logic                ex_is_load;
    pipe_pkg::id_to_ex_t id_to_ex;
    pipe_pkg::br_t       br;
    logic                stallreq;
    row_t                rows [$];

    id_stage UUT (
        .clk(clk), .rst(rst), .stall(stall), .if_to_id(if_to_id), .inst_rdata(inst_rdata),
        .wb_to_rf(wb_to_rf), .ex_fwd(ex_fwd), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
        .ex_is_load(ex_is_load), .id_to_ex(id_to_ex), .br(br), .stallreq(stallreq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    // Waits for a clock level within a few toggles
    task automatic wait_level(input logic level);
        int n;
        n = 0;
        while (n < 4) begin
            @(clk);
            n++;
            if (clk === level) break;
        end
        if (clk !== level) begin
            $display("Clock did not reach the expected level in time");
            report_failure();
        end
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    function automatic isa_pkg::word_t rtype(input int rs, rt, rd, sa, input logic [5:0] fn);
        return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic isa_pkg::word_t itype(input logic [5:0] op, input int rs, rt,
                                             input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic row_t blank_row(input isa_pkg::word_t pc, input isa_pkg::word_t inst);
        row_t r;
        r = '{default: '0};
        r.pc        = pc;
        r.inst      = inst;
        r.exp_valid = 1'b1;
        r.exp_pc    = pc;
        return r;
    endfunction

    function automatic isa_pkg::word_t auto_pc();
        return 32'h0000_0100 + 4 * rows.size();
    endfunction

    task automatic wr_row(input int addr, input isa_pkg::word_t data);
        row_t r;
        r = blank_row(auto_pc(), '0);
        r.wr = '{we: 1'b1, waddr: 5'(addr), wdata: data};
        rows.push_back(r);
    endtask

    task automatic rd_row(input int rs, rt, input isa_pkg::word_t e1, e2,
                          input pipe_pkg::fwd_t ex, mem, wbf);
        row_t r;
        r = blank_row(auto_pc(), rtype(rs, rt, 3, 0, 6'b100001));  // addu
        r.ex      = ex;
        r.mem     = mem;
        r.wbf     = wbf;
        r.chk_dat = 1'b1;
        r.exp_rd1 = e1;
        r.exp_rd2 = e2;
        rows.push_back(r);
    endtask

    task automatic ctl_row(input isa_pkg::word_t inst, input int alu_bit, input int s1, s2,
                           input logic men, input logic [3:0] wen, input logic we,
                           input int wa);
        row_t r;
        r = blank_row(auto_pc(), inst);
        r.chk_ctl = 1'b1;
        r.exp_ctl.alu_op   = (alu_bit < 0) ? '0 : isa_pkg::alu_op_t'(1) << alu_bit;
        r.exp_ctl.sel_src1 = s1;
        r.exp_ctl.sel_src2 = s2;
        r.exp_ctl.mem_en   = men;
        r.exp_ctl.mem_wen  = wen;
        r.exp_ctl.rf_we    = we;
        r.exp_ctl.rf_waddr = 5'(wa);
        rows.push_back(r);
    endtask

    task automatic br_row(input isa_pkg::word_t pc, inst, input logic taken,
                          input isa_pkg::word_t target);
        row_t r;
        r = blank_row(pc, inst);
        r.chk_br = 1'b1;
        r.exp_br = '{br_e: taken, br_addr: target};
        rows.push_back(r);
    endtask

    task automatic load_row(input int rs, rt, ex_addr, input logic exp_req);
        row_t r;
        r = blank_row(auto_pc(), rtype(rs, rt, 3, 0, 6'b100001));
        r.ex           = '{we: 1'b1, waddr: 5'(ex_addr), wdata: 32'h0};
        r.ld           = 1'b1;
        r.exp_stallreq = exp_req;
        rows.push_back(r);
    endtask

    task automatic stall_row(input logic if_s, id_s, input isa_pkg::word_t inst,
                             input logic exp_valid, input isa_pkg::word_t exp_pc);
        row_t r;
        r = blank_row(auto_pc(), inst);
        r.stall     = '{if_stall: if_s, id_stall: id_s};
        r.exp_valid = exp_valid;
        r.exp_pc    = exp_pc;
        r.chk_br    = 1'b1;  // Bubble must not branch
        rows.push_back(r);
    endtask

    task automatic build_table();
        pipe_pkg::fwd_t none;
        none = '0;
        wr_row(1, 32'd5);
        wr_row(2, 32'd5);
        wr_row(3, 32'hffff_fffd);
        wr_row(4, 32'd7);
        wr_row(0, 32'h0000_0123);
        rd_row(1, 2, 32'd5, 32'd5, none, none, none);
        rd_row(3, 4, 32'hffff_fffd, 32'd7, none, none, none);
        rd_row(0, 4, 32'd0, 32'd7, none, none, none);
        rd_row(1, 2, 32'd5, 32'haaaa, '{1'b1, 5'd2, 32'haaaa}, '{1'b1, 5'd2, 32'hbbbb},
               '{1'b1, 5'd2, 32'hcccc});
        rd_row(1, 2, 32'd5, 32'hbbbb, none, '{1'b1, 5'd2, 32'hbbbb}, '{1'b1, 5'd2, 32'hcccc});
        rd_row(1, 2, 32'd5, 32'hcccc, '{1'b0, 5'd2, 32'haaaa}, none, '{1'b1, 5'd2, 32'hcccc});
        rd_row(0, 2, 32'd0, 32'd5, '{1'b1, 5'd0, 32'haaaa}, none, none);
        ctl_row(rtype(1, 2, 3, 0, 6'b100001), `ALU_ADD, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b100011), `ALU_SUB, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b100100), `ALU_AND, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b100101), `ALU_OR, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b100110), `ALU_XOR, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b100111), `ALU_NOR, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b101010), `ALU_SLT, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b101011), `ALU_SLTU, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b000100), `ALU_SLL, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b000110), `ALU_SRL, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(1, 2, 3, 0, 6'b000111), `ALU_SRA, 1, 1, 0, 0, 1, 3);
        ctl_row(rtype(0, 2, 3, 4, 6'b000000), `ALU_SLL, 4, 1, 0, 0, 1, 3);
        ctl_row(rtype(0, 2, 3, 4, 6'b000010), `ALU_SRL, 4, 1, 0, 0, 1, 3);
        ctl_row(rtype(0, 2, 3, 4, 6'b000011), `ALU_SRA, 4, 1, 0, 0, 1, 3);
        ctl_row(itype(6'b001001, 1, 2, 16'h8001), `ALU_ADD, 1, 2, 0, 0, 1, 2);
        ctl_row(itype(6'b001010, 1, 2, 16'h0010), `ALU_SLT, 1, 2, 0, 0, 1, 2);
        ctl_row(itype(6'b001011, 1, 2, 16'h0010), `ALU_SLTU, 1, 2, 0, 0, 1, 2);
        ctl_row(itype(6'b001111, 0, 2, 16'h1234), `ALU_LUI, 0, 2, 0, 0, 1, 2);
        ctl_row(itype(6'b001100, 1, 2, 16'h00ff), `ALU_AND, 1, 8, 0, 0, 1, 2);
        ctl_row(itype(6'b001101, 1, 2, 16'h00ff), `ALU_OR, 1, 8, 0, 0, 1, 2);
        ctl_row(itype(6'b001110, 1, 2, 16'h00ff), `ALU_XOR, 1, 8, 0, 0, 1, 2);
        ctl_row(itype(6'b100011, 1, 2, 16'h0008), `ALU_ADD, 1, 2, 1, 4'h0, 1, 2);
        ctl_row(itype(6'b101011, 1, 2, 16'h0008), `ALU_ADD, 1, 2, 1, 4'hf, 0, 0);
        ctl_row(itype(6'b000100, 1, 2, 16'h0004), -1, 0, 0, 0, 0, 0, 0);
        ctl_row({6'b000010, 26'h100}, -1, 0, 0, 0, 0, 0, 0);
        ctl_row({6'b000011, 26'h100}, `ALU_ADD, 2, 4, 0, 0, 1, `LINK_REG);
        ctl_row(rtype(1, 0, 0, 0, 6'b001000), -1, 0, 0, 0, 0, 0, 0);
        ctl_row(rtype(4, 0, 31, 0, 6'b001001), `ALU_ADD, 2, 4, 0, 0, 1, 31);
        ctl_row(itype(6'b111111, 1, 2, 16'h0004), -1, 0, 0, 0, 0, 0, 0);  // Unknown opcode
        // r1 = r2 = 5, r3 negative, r4 = 7
        br_row(32'h1000, itype(6'b000100, 1, 2, 16'h0010), 1, 32'h1044);
        br_row(32'h1000, itype(6'b000100, 1, 4, 16'h0010), 0, 32'h0);
        br_row(32'h1000, itype(6'b000101, 1, 4, 16'hfffe), 1, 32'h0ffc);
        br_row(32'h1000, itype(6'b000101, 1, 2, 16'h0010), 0, 32'h0);
        br_row(32'h1000, itype(6'b000001, 1, 1, 16'h0010), 1, 32'h1044);
        br_row(32'h1000, itype(6'b000001, 3, 1, 16'h0010), 0, 32'h0);
        br_row(32'h1000, itype(6'b000001, 3, 0, 16'h0010), 1, 32'h1044);
        br_row(32'h1000, itype(6'b000001, 1, 0, 16'h0010), 0, 32'h0);
        br_row(32'h1000, itype(6'b000111, 1, 0, 16'h0010), 1, 32'h1044);
        br_row(32'h1000, itype(6'b000111, 0, 0, 16'h0010), 0, 32'h0);
        br_row(32'h1000, itype(6'b000110, 0, 0, 16'h0010), 1, 32'h1044);
        br_row(32'h1000, itype(6'b000110, 1, 0, 16'h0010), 0, 32'h0);
        br_row(32'h1000_0000, {6'b000010, 26'h100}, 1, 32'h1000_0400);
        br_row(32'h1000_0000, {6'b000011, 26'h100}, 1, 32'h1000_0400);
        br_row(32'h1000, rtype(1, 0, 0, 0, 6'b001000), 1, 32'd5);
        br_row(32'h1000, rtype(4, 0, 31, 0, 6'b001001), 1, 32'd7);
        load_row(1, 2, 2, 1'b1);
        load_row(1, 2, 1, 1'b1);
        load_row(1, 0, 0, 1'b0);
        load_row(1, 2, 5, 1'b0);
        stall_row(1'b1, 1'b0, {6'b000010, 26'h100}, 1'b0, 32'h0);
        rd_row(1, 2, 32'd5, 32'd5, none, none, none);
        stall_row(1'b1, 1'b1, '0, 1'b1, auto_pc() - 4);
    endtask

    initial begin
        row_t r;
        rst        = 1'b1;
        stall      = '0;
        if_to_id   = '0;
        inst_rdata = {6'b000010, 26'h100};  // Jump that the cleared ce must gate
        wb_to_rf   = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_is_load = 1'b0;
        build_table();
        repeat (4) wait_level(1'b1);
        rst <= 1'b0;
        wait_level(1'b0);
        check("valid after reset", id_to_ex.valid, 1'b0);
        check("br_e after reset", br.br_e, 1'b0);
        check("stallreq after reset", stallreq, 1'b0);
        foreach (rows[i]) begin
            r = rows[i];
            wait_level(1'b1);
            stall    <= r.stall;
            if_to_id <= '{ce: 1'b1, pc: r.pc};
            wb_to_rf <= r.wr;
            wait_level(1'b1);
            inst_rdata <= r.inst;  // SRAM word for the now registered pc
            ex_fwd     <= r.ex;
            mem_fwd    <= r.mem;
            wb_fwd     <= r.wbf;
            ex_is_load <= r.ld;
            wb_to_rf   <= '0;
            wait_level(1'b0);
            check("valid", id_to_ex.valid, r.exp_valid);
            check("pc", id_to_ex.pc, r.exp_pc);
            check("inst", id_to_ex.inst, r.inst);
            check("stallreq", stallreq, r.exp_stallreq);
            if (r.chk_ctl) begin
                check("alu_op", id_to_ex.alu_op, r.exp_ctl.alu_op);
                check("sel_src1", id_to_ex.sel_src1, r.exp_ctl.sel_src1);
                check("sel_src2", id_to_ex.sel_src2, r.exp_ctl.sel_src2);
                check("mem_en", id_to_ex.mem_en, r.exp_ctl.mem_en);
                check("mem_wen", id_to_ex.mem_wen, r.exp_ctl.mem_wen);
                check("rf_we", id_to_ex.rf_we, r.exp_ctl.rf_we);
                check("rf_waddr", id_to_ex.rf_waddr, r.exp_ctl.rf_waddr);
            end
            if (r.chk_dat) begin
                check("rdata1", id_to_ex.rdata1, r.exp_rd1);
                check("rdata2", id_to_ex.rdata2, r.exp_rd2);
            end
            if (r.chk_br) begin
                check("br_e", br.br_e, r.exp_br.br_e);
                if (r.exp_br.br_e) check("br_addr", br.br_addr, r.exp_br.br_addr);
            end
        end
        $display("No errors");
        $finish;
    end

endmodule
